// ==== verilog.f ====
+incdir+include
src/lc3b_isa_pkg.sv
src/lc3b_pipe_pkg.sv
src/lc3b_fetch.sv
src/lc3b_decode.sv
src/lc3b_execute.sv
src/lc3b_mem_wb.sv
src/lc3b_hazard.sv
src/lc3b_cpu.sv
sim/lc3b_cpu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := lc3b_cpu_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/lc3b_stimulus.txt ====
// Hex words. @00 program, one instruction word each. @80 data count, then byte address and value.
// @C0 expected store count, then byte address and stored data, in the order they occur.
@00
6C08 1225 147D 1642   // LDR R6 base; ADD R1 #5; ADD R2 R1 #-3; ADD R3 R1 R2
58E6 9B3F 5B43        // AND R4 R3 #6; NOT R5 R4; AND R5 R5 R3
7580 7781 7982 7B83   // STR R2..R5 at base +0..+3
9F7F 7F84             // NOT R7 R5; STR R7 at +4, data from MEM
6202 1461             // LDR R1, ADD on it right away
6603 182F 1AC4        // LDR R3; ADD R4 #15; ADD R5 R3 R4, load two back
6E04 1921 1921 53C4   // LDR R7; R4 += 1 twice; AND R1 R7 R4, load three back
67A4                  // LDR R3 R6 #-28, negative offset6
7585 7B86 7387 7788   // STR R2 R5 R1 R3 at +5..+8
13AE 1441 7442        // ADD R1 R6 #14; ADD R2 R1 R1; STR R2 R1 #2
6602 7643             // LDR R3; STR R3 R1 #3 with load data forwarded
6843 193F 798B        // Read back the store, decrement, STR at +11
1A20 0404             // ADD R5 R0 #0 sets Z; BRz +4
7D9F 7D9F 7D9F 7D9F   // Markers in the branch shadow
7B8C                  // Target, STR R5 at +12
6203 0804             // LDR R1 negative; BRn +4
7D9F 7D9F 7D9F 7D9F
738D                  // STR R1 at +13
1427 0C04 758E        // ADD R2 #7; BRnz falls through; STR R2 at +14
0004 738F             // BR with nzp 000; STR R1 at +15
0204 14A1             // BRp +4; ADD R2 in the shadow must not land
7D9F 7D9F 7D9F
7590 0FFF             // STR R2 at +16; BRnzp -1 parks the core
@80
0005                  // Initial data words
0004 1234
0006 8001
0008 00F0
0010 0080             // Store base
0048 0A5C
@C0
0011                  // Expected stores
0080 0002  0082 0007  0084 0006  0086 0001  0088 FFFE
008A 1235  008C 8010  008E 0010  0090 0A5C
0092 011C  0094 1234  0096 1233
0098 0000  009A 8001  009C 0007  009E 8001  00A0 0007

// ==== sim/lc3b_cpu_tb.sv ====
`include "lc3b_settings.svh"

module lc3b_cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    localparam int STIM_WORDS    = 256;
    localparam int PROG_WORDS    = 128;
    localparam int DATA_WORDS    = 256;
    localparam int MAX_STORES    = 32;
    localparam int DATA_BASE     = 'h80;  // Count followed by address and value pairs
    localparam int STORE_BASE    = 'hC0;
    localparam int STORE_TIMEOUT = 1000;  // Cycles
    localparam int TAIL_CYCLES   = 8;

    logic       clk;
    logic       rst;
    lc3b_word_t imem_rdata = '0;
    lc3b_word_t dmem_rdata = '0;
    lc3b_word_t imem_addr;
    dmem_req_t  dmem_req;

    lc3b_word_t stim [STIM_WORDS];
    lc3b_word_t imem [PROG_WORDS];
    lc3b_word_t dmem [DATA_WORDS];
    lc3b_word_t exp_addr [MAX_STORES];
    lc3b_word_t exp_data [MAX_STORES];
    int         num_stores = 0;
    int         seen_stores = 0;

    // Store seen in MEM is applied at the next rising edge
    logic       wr_pending = 1'b0;
    lc3b_word_t wr_addr = '0;
    lc3b_word_t wr_data = '0;

    lc3b_cpu dut0 (
        .clk          (clk),
        .i_rst        (rst),
        .i_imem_rdata (imem_rdata),
        .i_dmem_rdata (dmem_rdata),
        .o_imem_addr  (imem_addr),
        .o_dmem       (dmem_req)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input lc3b_word_t got, input lc3b_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Default data word built from every index bit
    function automatic lc3b_word_t fill_word(int index);
        logic [7:0] w;
        w = index[7:0];
        return {w, ~w};
    endfunction

    function automatic lc3b_word_t stim_word(int index);
        return stim[index[7:0]];
    endfunction

    task automatic load_stimulus();
        int         n_data;
        lc3b_word_t addr;
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim[i[7:0]] = '0;
        end
        $readmemh("sim/lc3b_stimulus.txt", stim);
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i[6:0]] = stim[i[7:0]];  // Unused words read as BR with nzp 000
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i[7:0]] = fill_word(i);
        end
        n_data = int'(stim_word(DATA_BASE));
        for (int i = 0; i < n_data; i++) begin
            addr = stim_word(DATA_BASE + 1 + 2 * i);
            dmem[addr[8:1]] = stim_word(DATA_BASE + 2 + 2 * i);
        end
        num_stores = int'(stim_word(STORE_BASE));
        if (num_stores == 0 || num_stores > MAX_STORES) begin
            report_failure("The stimulus file holds no usable list of expected stores");
        end else begin
            for (int i = 0; i < num_stores; i++) begin
                exp_addr[i[4:0]] = stim_word(STORE_BASE + 1 + 2 * i);
                exp_data[i[4:0]] = stim_word(STORE_BASE + 2 + 2 * i);
            end
        end
    endtask

    task automatic record_store(input lc3b_word_t addr, input lc3b_word_t data);
        if (seen_stores >= num_stores) begin
            report_failure($sformatf("Unexpected store to address %h after the last expected one",
                                     addr));
        end else begin
            check_value("o_dmem.addr", addr, exp_addr[seen_stores[4:0]]);
            check_value("o_dmem.wdata", data, exp_data[seen_stores[4:0]]);
            seen_stores++;
        end
    endtask

    // Memory answers and store capture on the falling edge
    always @(negedge clk) begin
        imem_rdata = (imem_addr[15:8] == 8'h00) ? imem[imem_addr[7:1]] : 16'h0000;
        dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[8:1]] : 16'h0000;  // Only on a read
        wr_pending = dmem_req.write;
        wr_addr    = dmem_req.addr;
        wr_data    = dmem_req.wdata;
        if (dmem_req.write) begin
            record_store(dmem_req.addr, dmem_req.wdata);
        end
    end

    always @(posedge clk) begin
        if (wr_pending) begin
            dmem[wr_addr[8:1]] = wr_data;
        end
    end

    initial begin
        int         wait_cycles;
        lc3b_word_t exp_pc;
        rst = 1'b1;
        load_stimulus();
        // PC parked and strobes quiet while in reset
        repeat (10) begin
            @(negedge clk);
            check_value("o_imem_addr", imem_addr, `LC3B_RESET_PC);
            check_value("o_dmem.read", lc3b_word_t'(dmem_req.read), 16'h0000);
            check_value("o_dmem.write", lc3b_word_t'(dmem_req.write), 16'h0000);
        end
        rst = 1'b0;
        exp_pc = `LC3B_RESET_PC;
        repeat (4) begin  // No branch can reach WB this early
            @(negedge clk);
            exp_pc = exp_pc + 16'd2;
            check_value("o_imem_addr", imem_addr, exp_pc);
        end
        wait_cycles = 0;
        while (seen_stores < num_stores && wait_cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (seen_stores < num_stores) begin
            report_failure($sformatf("Timeout, only %0d of %0d expected stores appeared",
                                     seen_stores, num_stores));
        end else begin
            repeat (TAIL_CYCLES) @(posedge clk);  // Window for stray stores
            $display("All tests passed");
            $finish;
        end
    end

endmodule : lc3b_cpu_tb

// ==== src/lc3b_cpu.sv ====
module lc3b_cpu (
    input  logic                     clk,
    input  logic                     i_rst,
    input  lc3b_isa_pkg::lc3b_word_t i_imem_rdata,
    input  lc3b_isa_pkg::lc3b_word_t i_dmem_rdata,
    output lc3b_isa_pkg::lc3b_word_t o_imem_addr,
    output lc3b_pipe_pkg::dmem_req_t o_dmem
);
    lc3b_pipe_pkg::if_id_t    if_id;
    lc3b_pipe_pkg::id_ex_t    id_ex;
    lc3b_pipe_pkg::ex_mem_t   ex_mem;
    lc3b_pipe_pkg::wb_fwd_t   wb;
    lc3b_pipe_pkg::fwd_sel_e  fwd_a;
    lc3b_pipe_pkg::fwd_sel_e  fwd_b;
    lc3b_isa_pkg::lc3b_word_t mem_fwd;
    lc3b_isa_pkg::lc3b_word_t target;
    logic                     redirect;
    logic                     flush;

    lc3b_fetch u_fetch (
        .clk, .i_rst, .i_imem_rdata,
        .i_redirect(redirect), .i_target(target), .i_flush(flush),
        .o_imem_addr, .o_if_id(if_id)
    );

    lc3b_decode u_decode (
        .clk, .i_rst, .i_if_id(if_id), .i_wb(wb), .i_flush(flush), .o_id_ex(id_ex)
    );

    lc3b_execute u_execute (
        .clk, .i_rst, .i_id_ex(id_ex), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_mem_fwd(mem_fwd), .i_wb(wb), .i_flush(flush), .o_ex_mem(ex_mem)
    );

    lc3b_mem_wb u_mem_wb (
        .clk, .i_rst, .i_ex_mem(ex_mem), .i_dmem_rdata,
        .o_dmem, .o_mem_fwd(mem_fwd), .o_wb(wb), .o_redirect(redirect), .o_target(target)
    );

    lc3b_hazard u_hazard (
        .i_id_ex(id_ex), .i_ex_mem(ex_mem), .i_wb(wb), .i_redirect(redirect),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_flush(flush)
    );

endmodule : lc3b_cpu

// ==== src/lc3b_hazard.sv ====
module lc3b_hazard (
    input  lc3b_pipe_pkg::id_ex_t   i_id_ex,
    input  lc3b_pipe_pkg::ex_mem_t  i_ex_mem,
    input  lc3b_pipe_pkg::wb_fwd_t  i_wb,
    input  logic                    i_redirect,
    output lc3b_pipe_pkg::fwd_sel_e o_fwd_a,
    output lc3b_pipe_pkg::fwd_sel_e o_fwd_b,
    output logic                    o_flush
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    // MEM holds the younger result, so it wins over WB
    function automatic fwd_sel_e pick_src(lc3b_reg_t src, ex_mem_t ex_mem, wb_fwd_t wb);
        fwd_sel_e sel;
        sel = fwd_none;
        if (ex_mem.ctrl.load_regfile && ex_mem.dest == src) begin
            sel = fwd_mem;
        end else if (wb.we && wb.dest == src) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    assign o_fwd_a = pick_src(i_id_ex.src1, i_ex_mem, i_wb);
    assign o_fwd_b = pick_src(i_id_ex.src2, i_ex_mem, i_wb);

    // Taken BR in WB squashes IF/ID, ID/EX and EX/MEM
    assign o_flush = i_redirect;

endmodule : lc3b_hazard

// ==== src/lc3b_mem_wb.sv ====
`include "lc3b_settings.svh"

module lc3b_mem_wb (
    input  logic                     clk,
    input  logic                     i_rst,
    input  lc3b_pipe_pkg::ex_mem_t   i_ex_mem,
    input  lc3b_isa_pkg::lc3b_word_t i_dmem_rdata,
    output lc3b_pipe_pkg::dmem_req_t o_dmem,
    output lc3b_isa_pkg::lc3b_word_t o_mem_fwd,
    output lc3b_pipe_pkg::wb_fwd_t   o_wb,
    output logic                     o_redirect,
    output lc3b_isa_pkg::lc3b_word_t o_target
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    mem_wb_t    mem_wb_q;
    lc3b_nzp_t  cc_q;
    lc3b_nzp_t  cc_next;
    lc3b_word_t wb_value;

    // MEM stage, the instruction here dies on a redirect
    assign o_dmem.addr  = i_ex_mem.alu;
    assign o_dmem.wdata = i_ex_mem.store_data;
    assign o_dmem.read  = i_ex_mem.ctrl.mem_read & ~o_redirect;
    assign o_dmem.write = i_ex_mem.ctrl.mem_write & ~o_redirect;
    assign o_mem_fwd    = i_ex_mem.ctrl.wb_mem ? i_dmem_rdata : i_ex_mem.alu;

    always_ff @(posedge clk) begin
        if (i_rst || o_redirect) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.ctrl      <= i_ex_mem.ctrl;
            mem_wb_q.dest      <= i_ex_mem.dest;
            mem_wb_q.alu       <= i_ex_mem.alu;
            mem_wb_q.load_data <= i_dmem_rdata;
            mem_wb_q.target    <= i_ex_mem.target;
            mem_wb_q.br_nzp    <= i_ex_mem.br_nzp;
        end
    end

    assign wb_value   = mem_wb_q.ctrl.wb_mem ? mem_wb_q.load_data : mem_wb_q.alu;
    assign o_wb.we    = mem_wb_q.ctrl.load_regfile;
    assign o_wb.dest  = mem_wb_q.dest;
    assign o_wb.value = wb_value;

    always_comb begin
        if (wb_value[`LC3B_WORD_W-1]) begin
            cc_next = 3'b100;
        end else if (wb_value == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cc_q <= `LC3B_RESET_CC;
        end else if (mem_wb_q.ctrl.load_cc) begin
            cc_q <= cc_next;
        end
    end

    // nzp of 000 never matches
    assign o_redirect = (mem_wb_q.ctrl.opcode == op_br) && |(mem_wb_q.br_nzp & cc_q);
    assign o_target   = mem_wb_q.target;

    a_one_strobe: assert property (@(posedge clk) disable iff (i_rst)
        !(o_dmem.read && o_dmem.write))
        else $error("read and write strobe together");

endmodule : lc3b_mem_wb

// ==== src/lc3b_execute.sv ====
module lc3b_execute (
    input  logic                     clk,
    input  logic                     i_rst,
    input  lc3b_pipe_pkg::id_ex_t    i_id_ex,
    input  lc3b_pipe_pkg::fwd_sel_e  i_fwd_a,
    input  lc3b_pipe_pkg::fwd_sel_e  i_fwd_b,
    input  lc3b_isa_pkg::lc3b_word_t i_mem_fwd,
    input  lc3b_pipe_pkg::wb_fwd_t   i_wb,
    input  logic                     i_flush,
    output lc3b_pipe_pkg::ex_mem_t   o_ex_mem
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_word_t opnd_a;
    lc3b_word_t opnd_b;
    lc3b_word_t imm5_sext;
    lc3b_word_t off6_sext;
    lc3b_word_t off9_sext;
    lc3b_word_t imm_val;
    lc3b_word_t alu_b;
    lc3b_word_t alu_out;
    lc3b_word_t target;
    lc3b_nzp_t  br_nzp;
    logic       is_mem;

    function automatic lc3b_word_t fwd_pick(fwd_sel_e sel, lc3b_word_t reg_val,
                                            lc3b_word_t mem_val, lc3b_word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign opnd_a = fwd_pick(i_fwd_a, i_id_ex.src1_val, i_mem_fwd, i_wb.value);
    assign opnd_b = fwd_pick(i_fwd_b, i_id_ex.src2_val, i_mem_fwd, i_wb.value);

    assign imm5_sext = lc3b_word_t'($signed(i_id_ex.imm5));
    assign off6_sext = lc3b_word_t'($signed(i_id_ex.offset6));
    assign off9_sext = lc3b_word_t'($signed(i_id_ex.offset9));

    // Word offsets scale by two
    assign is_mem  = i_id_ex.ctrl.mem_read | i_id_ex.ctrl.mem_write;
    assign imm_val = is_mem ? (off6_sext << 1) : imm5_sext;
    assign alu_b   = i_id_ex.ctrl.imm_sel ? imm_val : opnd_b;

    always_comb begin
        case (i_id_ex.ctrl.aluop)
            alu_add: alu_out = opnd_a + alu_b;
            alu_and: alu_out = opnd_a & alu_b;
            alu_not: alu_out = ~opnd_a;
            default: alu_out = opnd_a;
        endcase
    end

    assign target = i_id_ex.pc2 + (off9_sext << 1);
    assign br_nzp = (i_id_ex.ctrl.opcode == op_br) ? i_id_ex.dest : '0;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.ctrl       <= i_id_ex.ctrl;
            o_ex_mem.dest       <= i_id_ex.dest;
            o_ex_mem.alu        <= alu_out;
            o_ex_mem.store_data <= opnd_b;  // STR data, already forwarded
            o_ex_mem.target     <= target;
            o_ex_mem.br_nzp     <= br_nzp;
        end
    end

    // Forward selects from hazard must point at a stage that writes the regfile
    a_fwd_live: assert property (@(posedge clk) disable iff (i_rst)
        ((i_fwd_a == fwd_mem || i_fwd_b == fwd_mem) |-> o_ex_mem.ctrl.load_regfile) and
        ((i_fwd_a == fwd_wb || i_fwd_b == fwd_wb) |-> i_wb.we))
        else $error("forward from idle stage");

endmodule : lc3b_execute

// ==== src/lc3b_decode.sv ====
`include "lc3b_settings.svh"

module lc3b_decode (
    input  logic                    clk,
    input  logic                    i_rst,
    input  lc3b_pipe_pkg::if_id_t   i_if_id,
    input  lc3b_pipe_pkg::wb_fwd_t  i_wb,
    input  logic                    i_flush,
    output lc3b_pipe_pkg::id_ex_t   o_id_ex
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_word_t   regs [`LC3B_NUM_REGS];
    lc3b_word_t   instr;
    lc3b_opcode_e opcode;
    lc3b_reg_t    src1;
    lc3b_reg_t    src2;
    lc3b_word_t   src1_val;
    lc3b_word_t   src2_val;
    ctrl_word_t   ctrl;

    assign instr  = i_if_id.instr;
    assign opcode = lc3b_opcode_e'(instr[15:12]);
    assign src1   = instr[8:6];
    assign src2   = (opcode == op_str) ? instr[11:9] : instr[2:0];  // STR data on port B

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = opcode;
        case (opcode)
            op_add, op_and: begin
                ctrl.aluop        = (opcode == op_add) ? alu_add : alu_and;
                ctrl.imm_sel      = instr[5];
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_not: begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_ldr: begin
                ctrl.aluop        = alu_add;  // Base plus offset6
                ctrl.imm_sel      = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.wb_mem       = 1'b1;
            end
            op_str: begin
                ctrl.aluop     = alu_add;
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            // BR resolves in WB from its nzp; anything else has no effect
            default: ;
        endcase
        if (!i_if_id.valid) begin
            ctrl = '0;
        end
    end

    // Write in the same cycle shows up here through the bypass
    assign src1_val = (i_wb.we && i_wb.dest == src1) ? i_wb.value : regs[src1];
    assign src2_val = (i_wb.we && i_wb.dest == src2) ? i_wb.value : regs[src2];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we) begin
            regs[i_wb.dest] <= i_wb.value;
        end
    end

    // ID/EX
    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.ctrl     <= ctrl;
            o_id_ex.pc2      <= i_if_id.pc2;
            o_id_ex.dest     <= instr[11:9];
            o_id_ex.src1     <= src1;
            o_id_ex.src2     <= src2;
            o_id_ex.src1_val <= src1_val;
            o_id_ex.src2_val <= src2_val;
            o_id_ex.imm5     <= instr[4:0];
            o_id_ex.offset6  <= instr[5:0];
            o_id_ex.offset9  <= instr[8:0];
        end
    end

endmodule : lc3b_decode

// ==== src/lc3b_fetch.sv ====
`include "lc3b_settings.svh"

module lc3b_fetch (
    input  logic                     clk,
    input  logic                     i_rst,
    input  lc3b_isa_pkg::lc3b_word_t i_imem_rdata,
    input  logic                     i_redirect,
    input  lc3b_isa_pkg::lc3b_word_t i_target,
    input  logic                     i_flush,
    output lc3b_isa_pkg::lc3b_word_t o_imem_addr,
    output lc3b_pipe_pkg::if_id_t    o_if_id
);
    import lc3b_isa_pkg::*;

    lc3b_word_t pc_q;
    lc3b_word_t pc_plus2;

    assign pc_plus2    = pc_q + lc3b_word_t'(2);
    assign o_imem_addr = pc_q;  // Zero-wait memory, word comes back this cycle

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q <= `LC3B_RESET_PC;
        end else if (i_redirect) begin
            pc_q <= i_target;  // Taken BR from WB
        end else begin
            pc_q <= pc_plus2;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_if_id <= '0;
        end else begin
            o_if_id.valid <= 1'b1;
            o_if_id.pc2   <= pc_plus2;
            o_if_id.instr <= i_imem_rdata;
        end
    end

    // Branch targets come back from EX through WB
    a_pc_even: assert property (@(posedge clk) disable iff (i_rst) !pc_q[0])
        else $error("odd PC %h", pc_q);

endmodule : lc3b_fetch

// ==== src/lc3b_pipe_pkg.sv ====
`include "lc3b_settings.svh"

package lc3b_pipe_pkg;
    import lc3b_isa_pkg::*;

    typedef struct packed {
        lc3b_opcode_e opcode;
        lc3b_aluop_e  aluop;
        logic         imm_sel;       // Operand B from the immediate
        logic         mem_read;
        logic         mem_write;
        logic         load_regfile;
        logic         load_cc;
        logic         wb_mem;        // Write back load data, not ALU result
    } ctrl_word_t;

    typedef struct packed {
        logic       valid;
        lc3b_word_t pc2;
        lc3b_word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t    ctrl;
        lc3b_word_t    pc2;
        lc3b_reg_t     dest;         // Also carries BR nzp
        lc3b_reg_t     src1;
        lc3b_reg_t     src2;
        lc3b_word_t    src1_val;
        lc3b_word_t    src2_val;
        lc3b_imm5_t    imm5;
        lc3b_offset6_t offset6;
        lc3b_offset9_t offset9;
    } id_ex_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        lc3b_reg_t  dest;
        lc3b_word_t alu;
        lc3b_word_t store_data;
        lc3b_word_t target;
        lc3b_nzp_t  br_nzp;
    } ex_mem_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        lc3b_reg_t  dest;
        lc3b_word_t alu;
        lc3b_word_t load_data;
        lc3b_word_t target;
        lc3b_nzp_t  br_nzp;
    } mem_wb_t;

    // Word access only
    typedef struct packed {
        logic [`LC3B_WORD_W-1:0] addr;
        logic [`LC3B_WORD_W-1:0] wdata;
        logic                    read;
        logic                    write;
    } dmem_req_t;

    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } fwd_sel_e;

    // Regfile write port, doubles as the WB forward source
    typedef struct packed {
        logic       we;
        lc3b_reg_t  dest;
        lc3b_word_t value;
    } wb_fwd_t;

endpackage : lc3b_pipe_pkg

// ==== src/lc3b_isa_pkg.sv ====
`include "lc3b_settings.svh"

package lc3b_isa_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word_t;
    typedef logic [2:0] lc3b_reg_t;
    typedef logic [2:0] lc3b_nzp_t;  // N, Z, P

    // Instruction fields
    typedef logic [4:0] lc3b_imm5_t;
    typedef logic [5:0] lc3b_offset6_t;
    typedef logic [8:0] lc3b_offset9_t;

    // Full opcode map, only part of it executes
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode_e;

    typedef enum logic [1:0] {
        alu_pass = 2'b00,  // Zero so an empty control word passes A
        alu_add  = 2'b01,
        alu_and  = 2'b10,
        alu_not  = 2'b11
    } lc3b_aluop_e;

endpackage : lc3b_isa_pkg

// ==== include/lc3b_settings.svh ====
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// Data and address width
`define LC3B_WORD_W 16

`define LC3B_NUM_REGS 8  // R0 to R7

// First fetch address
`define LC3B_RESET_PC 16'h0000

`define LC3B_RESET_CC 3'b010  // Z set out of reset

`endif
